/* logic/cu_pkg.sv */
//==========================================================================
// shared opcodes, funct3 codes, alu codes and control-word layout
// for the pipeline control unit; every block imports what it needs
//==========================================================================
package cu_pkg;

    // base opcodes, instr[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_CSTYPE = 7'b1110011;

    // funct3, shared by register and immediate arithmetic
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_PASS = 4'd0,    // lui, and the fallback
        ALU_ADD  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_AND  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SUB  = 4'd9,
        ALU_SLT  = 4'd10,
        ALU_SLTU = 4'd11
    } alu_op_t;

    // one group per pipeline stage, msb first
    typedef struct packed {
        logic [1:0] fetch;      // pc_en, fd_en
        logic [3:0] decode;     // reg1_en, reg2_en, imm_en, de_en
        logic [2:0] execute;    // mux_a_sel, mux_b_sel, em_en
        logic [2:0] memory;     // dram_we, dram_re, mw_en
        logic [2:0] writeback;  // mux_c_sel, mux_d_sel, rf_we
    } cw_t;

    // instruction classes, index into cw_table
    localparam int CLS_BRANCH  = 0;
    localparam int CLS_JAL     = 1;
    localparam int CLS_JALR    = 2;
    localparam int CLS_LOAD    = 3;
    localparam int CLS_STORE   = 4;
    localparam int CLS_ITYPE   = 5;
    localparam int CLS_RTYPE   = 6;
    localparam int CLS_FENCE   = 7;
    localparam int CLS_CSTYPE  = 8;
    localparam int NUM_CLASSES = 9;

    localparam cw_t cw_table [0:NUM_CLASSES-1] = '{
        15'b11_1111_111_001_100,    // branch
        15'b11_0011_101_001_111,    // jal
        15'b11_1011_011_001_111,    // jalr
        15'b11_1011_111_011_001,    // load
        15'b11_1111_111_101_100,    // store
        15'b11_1011_111_001_101,    // immediate
        15'b11_1101_101_001_101,    // rtype
        15'b11_1101_101_001_101,    // fence
        15'b11_1101_101_001_101     // cstype
    };

    // zero word while the icache fills, pc keeps moving
    localparam cw_t cw_fetch_only = 15'b11_0000_000_000_000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // rd slot carries immediate bits
        logic [6:0] opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_t r;
        instr_s_t s;
    } instr_t;

endpackage

/* logic/cw_bundle_if.sv */
//==========================================================================
// decoded control word travelling from the decoder into the stage
// registers; decoder drives it, pipeline reads it
//==========================================================================
`timescale 1ns/1ps

interface cw_bundle_if
    import cu_pkg::*;
();

    logic [1:0] fetch;
    logic [3:0] decode;
    logic [2:0] execute;
    logic [2:0] memory;
    logic [2:0] writeback;
    alu_op_t    alu_op;
    logic       is_zero_instr;  // icache fill word

    modport decoder (
        output fetch, decode, execute, memory, writeback, alu_op, is_zero_instr
    );

    modport pipeline (
        input fetch, decode, execute, memory, writeback, alu_op, is_zero_instr
    );

endinterface

/* logic/cw_decoder.sv */
//==========================================================================
// combinational decode of the fetched word into the stage groups
// and the alu operation code
//==========================================================================
`timescale 1ns/1ps

module cw_decoder
    import cu_pkg::*;
(
    input  instr_t       instr,
    cw_bundle_if.decoder cw
);

    cw_t     word;
    alu_op_t op;
    logic    is_zero;
    logic    is_rtype;
    logic    alt;

    assign is_zero  = (instr == '0);
    assign is_rtype = (instr.r.opcode == OP_RTYPE);
    assign alt      = instr.r.funct7[5];  // bit 30, sub and sra/srai

    always_comb begin
        if (is_zero) begin
            word = cw_fetch_only;
        end else begin
            case (instr.r.opcode)
                OP_BRANCH: word = cw_table[CLS_BRANCH];
                OP_JAL:    word = cw_table[CLS_JAL];
                OP_JALR:   word = cw_table[CLS_JALR];
                OP_LOAD:   word = cw_table[CLS_LOAD];
                OP_STORE:  word = cw_table[CLS_STORE];
                OP_ITYPE:  word = cw_table[CLS_ITYPE];
                OP_RTYPE:  word = cw_table[CLS_RTYPE];
                OP_FENCE:  word = cw_table[CLS_FENCE];
                OP_CSTYPE: word = cw_table[CLS_CSTYPE];
                default:   word = '0;  // unknown opcode launches nothing
            endcase
        end
    end

    always_comb begin
        case (instr.r.opcode)
            OP_LUI:             op = ALU_PASS;
            OP_LOAD, OP_STORE:  op = ALU_ADD;   // address add
            OP_RTYPE, OP_ITYPE: begin
                case (instr.r.funct3)
                    F3_ADD_SUB: op = (is_rtype && alt) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     op = ALU_SLL;
                    F3_SLT:     op = ALU_SLT;
                    F3_SLTU:    op = ALU_SLTU;
                    F3_XOR:     op = ALU_XOR;
                    F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      op = ALU_OR;
                    F3_AND:     op = ALU_AND;
                    default:    op = ALU_PASS;
                endcase
            end
            default:            op = ALU_PASS;
        endcase
    end

    assign cw.fetch         = word.fetch;
    assign cw.decode        = word.decode;
    assign cw.execute       = word.execute;
    assign cw.memory        = word.memory;
    assign cw.writeback     = word.writeback;
    assign cw.alu_op        = op;
    assign cw.is_zero_instr = is_zero;

endmodule

/* logic/hazard_unit.sv */
//==========================================================================
// read-after-write detection against the previous instruction;
// flags are combinational and valid in the cycle the reader is fetched
//==========================================================================
`timescale 1ns/1ps

module hazard_unit
    import cu_pkg::*;
(
    input  logic   clk,
    input  logic   nrst,
    input  instr_t instr,
    input  logic   insert_bubble,
    input  logic   flush,
    output logic   load_use,
    output logic   alu_branch,
    output logic   load_branch
);

    logic [6:0] opcode;
    logic       is_branch;
    logic       is_load;
    logic       s_form;
    logic       no_rs1;
    logic       no_rs2;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [4:0] prev_rd;
    logic       prev_load;
    logic       match;

    assign opcode    = instr.r.opcode;
    assign is_branch = (opcode == OP_BRANCH);
    assign is_load   = (opcode == OP_LOAD);
    assign s_form    = is_branch || (opcode == OP_STORE);   // imm_lo in the rd slot

    // classes without a given source field
    assign no_rs1 = (opcode == OP_JAL) || (opcode == OP_LUI) || (opcode == OP_AUIPC);
    assign no_rs2 = no_rs1 || is_load || (opcode == OP_ITYPE);

    // sources sit at the same bits in both views
    assign rs1 = no_rs1 ? 5'd0 : instr.s.rs1;
    assign rs2 = no_rs2 ? 5'd0 : instr.s.rs2;
    assign rd  = s_form ? 5'd0 : instr.r.rd;

    // a killed slot writes nothing, so a held reader is not caught twice
    always_ff @(posedge clk) begin
        if (!nrst) begin
            prev_rd   <= 5'd0;
            prev_load <= 1'b0;
        end else if (insert_bubble || flush) begin
            prev_rd   <= 5'd0;
            prev_load <= 1'b0;
        end else begin
            prev_rd   <= rd;
            prev_load <= is_load;
        end
    end

    assign match = (prev_rd != 5'd0) && ((rs1 == prev_rd) || (rs2 == prev_rd));

    assign load_use    = match && prev_load && !is_branch;
    assign load_branch = match && prev_load && is_branch;   // waits on memory
    assign alu_branch  = match && !prev_load && is_branch;

endmodule

/* logic/stall_fsm.sv */
//==========================================================================
// turns hazards, the external stall and the misprediction flush into
// hold and bubble levels; starts the memory wait on load-then-branch
//==========================================================================
`timescale 1ns/1ps

module stall_fsm #(
    parameter int MEM_DELAY = 3
) (
    input  logic clk,
    input  logic nrst,
    input  logic stall,
    input  logic chng2nop,
    input  logic load_use,
    input  logic alu_branch,
    input  logic load_branch,
    input  logic done,
    output logic start,
    output logic hold_fetch,
    output logic insert_bubble,
    output logic flush
);

    typedef enum logic [1:0] {
        RESET,
        RUN,
        MEM_WAIT
    } state_t;

    state_t state;
    state_t next_state;

    // the wait counter is four bits wide
    if (MEM_DELAY < 1 || MEM_DELAY > 15) begin : g_delay_range
        $error("MEM_DELAY must lie in 1..15");
    end

    always_ff @(posedge clk) begin
        if (!nrst)
            state <= RESET;
        else
            state <= next_state;
    end

    always_comb begin
        next_state    = state;
        start         = 1'b0;
        hold_fetch    = 1'b0;
        insert_bubble = 1'b0;
        flush         = 1'b0;
        case (state)
            RESET: begin
                flush      = 1'b1;  // keep the pipe empty until running
                next_state = RUN;
            end
            RUN: begin
                if (chng2nop) begin
                    flush = 1'b1;
                end else if (stall) begin
                    hold_fetch    = 1'b1;
                    insert_bubble = 1'b1;
                end else if (load_branch) begin
                    start         = 1'b1;
                    hold_fetch    = 1'b1;
                    insert_bubble = 1'b1;
                    next_state    = MEM_WAIT;
                end else if (load_use || alu_branch) begin
                    hold_fetch    = 1'b1;   // one cycle only
                    insert_bubble = 1'b1;
                end
            end
            MEM_WAIT: begin
                flush         = chng2nop;
                hold_fetch    = 1'b1;
                insert_bubble = 1'b1;
                if (done)
                    next_state = RUN;
            end
            default: next_state = RESET;
        endcase
    end

endmodule

/* logic/delay_counter.sv */
//==========================================================================
// counts the memory latency of a load feeding a branch;
// done pulses MEM_DELAY cycles after start
//==========================================================================
`timescale 1ns/1ps

module delay_counter #(
    parameter int MEM_DELAY = 3
) (
    input  logic clk,
    input  logic nrst,
    input  logic start,
    output logic done
);

    logic [3:0] count;
    logic       running;

    assign done = running && (count == 4'(MEM_DELAY));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            count   <= 4'd0;
            running <= 1'b0;
        end else if (done) begin
            count   <= 4'd0;    // back to idle
            running <= 1'b0;
        end else if (running) begin
            count <= count + 4'd1;
        end else if (start) begin
            count   <= 4'd1;    // first wait cycle
            running <= 1'b1;
        end
    end

endmodule

/* logic/cw_pipeline.sv */
//==========================================================================
// stage registers that carry each control group to its own stage,
// with bubble and flush injection at the decode boundary
//==========================================================================
`timescale 1ns/1ps

module cw_pipeline
    import cu_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,
    input  logic          hold_fetch,
    input  logic          insert_bubble,
    input  logic          flush,
    cw_bundle_if.pipeline cw,
    output cw_t           cw_out,
    output alu_op_t       alu_ctrl,
    output logic          rf_we
);

    logic [12:0] de_stage;  // decode .. writeback
    logic [8:0]  ex_stage;  // execute .. writeback
    logic [5:0]  mem_stage; // memory, writeback
    logic [2:0]  wb_stage;
    alu_op_t     alu_de;
    alu_op_t     alu_ex;
    logic        kill;

    assign kill = insert_bubble || flush;

    // older groups keep moving while the front is held
    always_ff @(posedge clk) begin
        if (!nrst) begin
            de_stage  <= '0;
            ex_stage  <= '0;
            mem_stage <= '0;
            wb_stage  <= '0;
        end else begin
            de_stage  <= kill ? 13'd0 : {cw.decode, cw.execute, cw.memory, cw.writeback};
            ex_stage  <= de_stage[8:0];
            mem_stage <= ex_stage[5:0];
            wb_stage  <= mem_stage[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            alu_de <= ALU_PASS;
            alu_ex <= ALU_PASS;
        end else begin
            // fill words and killed slots never drive the alu
            alu_de <= (kill || cw.is_zero_instr) ? ALU_PASS : cw.alu_op;
            alu_ex <= alu_de;
        end
    end

    always_comb begin
        cw_out.fetch     = (hold_fetch || flush) ? 2'b00 : cw.fetch;
        cw_out.decode    = de_stage[12:9];
        cw_out.execute   = ex_stage[8:6];
        cw_out.memory    = mem_stage[5:3];
        cw_out.writeback = wb_stage;
    end

    assign alu_ctrl = alu_ex;       // lines up with the execute group
    assign rf_we    = wb_stage[0];

endmodule

/* logic/cu_top.sv */
//==========================================================================
// control unit top; one instruction word in per cycle, stage-aligned
// control word, alu code and register-file write enable out
//==========================================================================
`timescale 1ns/1ps

module cu_top
    import cu_pkg::*;
#(
    parameter int MEM_DELAY = 3     // load latency seen by a branch, 1..15
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        stall,
    input  logic        chng2nop,
    input  logic [31:0] instr_in,
    output logic [14:0] cw_out,
    output logic [3:0]  alu_ctrl,
    output logic        rf_we
);

    instr_t  instr;
    cw_t     cw_word;
    alu_op_t alu_word;
    logic    load_use;
    logic    alu_branch;
    logic    load_branch;
    logic    start;
    logic    done;
    logic    hold_fetch;
    logic    insert_bubble;
    logic    flush;

    assign instr = instr_t'(instr_in);

    cw_bundle_if cw_if ();

    cw_decoder cw_decoder_inst (
        .instr (instr),
        .cw    (cw_if.decoder)
    );

    hazard_unit hazard_unit_inst (
        .clk           (clk),
        .nrst          (nrst),
        .instr         (instr),
        .insert_bubble (insert_bubble),
        .flush         (flush),
        .load_use      (load_use),
        .alu_branch    (alu_branch),
        .load_branch   (load_branch)
    );

    stall_fsm #(.MEM_DELAY(MEM_DELAY)) stall_fsm_inst (
        .clk           (clk),
        .nrst          (nrst),
        .stall         (stall),
        .chng2nop      (chng2nop),
        .load_use      (load_use),
        .alu_branch    (alu_branch),
        .load_branch   (load_branch),
        .done          (done),
        .start         (start),
        .hold_fetch    (hold_fetch),
        .insert_bubble (insert_bubble),
        .flush         (flush)
    );

    delay_counter #(.MEM_DELAY(MEM_DELAY)) delay_counter_inst (
        .clk   (clk),
        .nrst  (nrst),
        .start (start),
        .done  (done)
    );

    cw_pipeline cw_pipeline_inst (
        .clk           (clk),
        .nrst          (nrst),
        .hold_fetch    (hold_fetch),
        .insert_bubble (insert_bubble),
        .flush         (flush),
        .cw            (cw_if.pipeline),
        .cw_out        (cw_word),
        .alu_ctrl      (alu_word),
        .rf_we         (rf_we)
    );

    assign cw_out   = cw_word;
    assign alu_ctrl = alu_word;

endmodule

/* bench/cu_props.sv */
//==========================================================================
// bound checker for the control unit; keeps its own shadow of the stage
// registers, hazards and memory wait, and compares every cycle
//==========================================================================
`timescale 1ns/1ps

module cu_props
    import cu_pkg::*;
#(
    parameter int MEM_DELAY = 3
) (
    input logic        clk,
    input logic        nrst,
    input logic        stall,
    input logic        chng2nop,
    input logic [31:0] instr_in,
    input logic [14:0] cw_out,
    input logic [3:0]  alu_ctrl,
    input logic        rf_we
);

    // funct3 to operation before the bit 30 variants
    localparam alu_op_t F3_OP [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                      ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

    instr_t     w;
    cw_t        word;
    cw_t        d1;
    cw_t        d2;
    cw_t        d3;
    cw_t        d4;
    cw_t        exp_cw;
    alu_op_t    alu1;
    alu_op_t    alu2;
    logic [6:0] op;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [4:0] prev_rd;
    logic       prev_load;
    logic       running;
    logic       dep;
    logic       kill;
    logic       start_wait;
    logic [3:0] wait_left;
    int         errors = 0;     // failed assertion count

    function automatic cw_t class_word(input instr_t i);
        if (i == '0)
            return cw_fetch_only;
        case (i.r.opcode)
            OP_BRANCH: return cw_table[CLS_BRANCH];
            OP_JAL:    return cw_table[CLS_JAL];
            OP_JALR:   return cw_table[CLS_JALR];
            OP_LOAD:   return cw_table[CLS_LOAD];
            OP_STORE:  return cw_table[CLS_STORE];
            OP_ITYPE:  return cw_table[CLS_ITYPE];
            OP_RTYPE:  return cw_table[CLS_RTYPE];
            OP_FENCE:  return cw_table[CLS_FENCE];
            OP_CSTYPE: return cw_table[CLS_CSTYPE];
            default:   return '0;
        endcase
    endfunction

    function automatic alu_op_t alu_rule(input instr_t i);
        alu_op_t base;
        base = F3_OP[i.r.funct3];
        if (i.r.opcode == OP_LOAD || i.r.opcode == OP_STORE)
            return ALU_ADD;
        if (i.r.opcode != OP_RTYPE && i.r.opcode != OP_ITYPE)
            return ALU_PASS;
        if (i.r.funct7[5] && base == ALU_SRL)
            return ALU_SRA;
        if (i.r.funct7[5] && base == ALU_ADD && i.r.opcode == OP_RTYPE)
            return ALU_SUB;     // addi ignores bit 30
        return base;
    endfunction

    assign w    = instr_t'(instr_in);
    assign op   = w.r.opcode;
    assign word = class_word(w);

    assign rs1 = (op == OP_JAL || op == OP_LUI || op == OP_AUIPC) ? 5'd0 : w.r.rs1;
    assign rs2 = (op == OP_JAL || op == OP_LUI || op == OP_AUIPC || op == OP_LOAD ||
                  op == OP_ITYPE) ? 5'd0 : w.r.rs2;
    assign rd  = (op == OP_BRANCH || op == OP_STORE) ? 5'd0 : w.r.rd;

    // only load-then-anything and anything-then-branch hold the front
    assign dep = (prev_rd != 5'd0) && (rs1 == prev_rd || rs2 == prev_rd) &&
                 (prev_load || op == OP_BRANCH);
    assign start_wait = running && wait_left == 4'd0 && !chng2nop && !stall && dep &&
                        prev_load && op == OP_BRANCH;
    assign kill = !running || chng2nop || stall || wait_left != 4'd0 || dep;

    always_comb begin
        exp_cw.fetch     = kill ? 2'b00 : word.fetch;
        exp_cw.decode    = d1.decode;
        exp_cw.execute   = d2.execute;
        exp_cw.memory    = d3.memory;
        exp_cw.writeback = d4.writeback;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            running   <= 1'b0;
            d1        <= '0;
            d2        <= '0;
            d3        <= '0;
            d4        <= '0;
            alu1      <= ALU_PASS;
            alu2      <= ALU_PASS;
            prev_rd   <= 5'd0;
            prev_load <= 1'b0;
            wait_left <= 4'd0;
        end else begin
            running   <= 1'b1;
            d1        <= kill ? cw_t'(0) : word;
            d2        <= d1;
            d3        <= d2;
            d4        <= d3;
            alu1      <= kill ? ALU_PASS : alu_rule(w);
            alu2      <= alu1;
            prev_rd   <= kill ? 5'd0 : rd;
            prev_load <= !kill && op == OP_LOAD;
            if (start_wait)
                wait_left <= 4'(MEM_DELAY);
            else if (wait_left != 4'd0)
                wait_left <= wait_left - 4'd1;
        end
    end

    a_reset: assert property (@(posedge clk) !nrst |=> (cw_out == '0 && alu_ctrl == '0 && !rf_we))
        else begin
            $error("outputs not cleared by reset, cw_out %h", $sampled(cw_out));
            errors++;
        end

    a_cw: assert property (@(posedge clk) disable iff (!nrst) cw_out == exp_cw)
        else begin
            $error("cw_out expected %h actual %h", $sampled(exp_cw), $sampled(cw_out));
            errors++;
        end

    a_alu: assert property (@(posedge clk) disable iff (!nrst) alu_ctrl == alu2)
        else begin
            $error("alu_ctrl expected %0d actual %0d", $sampled(alu2), $sampled(alu_ctrl));
            errors++;
        end

    a_rf_we: assert property (@(posedge clk) disable iff (!nrst) rf_we == d4.writeback[0])
        else begin
            $error("rf_we expected %b actual %b", $sampled(d4.writeback[0]), $sampled(rf_we));
            errors++;
        end

    // load feeding a branch holds fetch for the whole memory wait
    a_mem_wait: assert property (@(posedge clk) disable iff (!nrst)
            start_wait |-> (cw_out[14:13] == 2'b00) [*MEM_DELAY+1])
        else begin
            $error("fetch group released early during the memory wait");
            errors++;
        end

endmodule

bind cu_top cu_props #(.MEM_DELAY(MEM_DELAY)) cu_props_inst (.*);

/* bench/tb_cu.sv */
//==========================================================================
// testbench for the control unit; drives instruction sequences while
// the bound checker compares outputs, reports per test and in total
//==========================================================================
`timescale 1ns/1ps

module tb_cu;
    import cu_pkg::*;

    localparam int MEM_DELAY    = 3;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    // reset, alignment, alu, flush, stalls, memory wait
    localparam int TEST_CYCLES  = 16 + 25 + 75 + 7 + 20 + (MEM_DELAY + 8);
    localparam int WATCHDOG_NS  = TEST_CYCLES * 2 * CLK_PERIOD;

    logic        clk;
    logic        nrst;
    logic        stall;
    logic        chng2nop;
    logic [31:0] instr_in;
    logic [14:0] cw_out;
    logic [3:0]  alu_ctrl;
    logic        rf_we;
    integer      seed = 32'h2f6f;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_before = 0;

    cu_top #(.MEM_DELAY(MEM_DELAY)) cu_top_inst (
        .clk      (clk),
        .nrst     (nrst),
        .stall    (stall),
        .chng2nop (chng2nop),
        .instr_in (instr_in),
        .cw_out   (cw_out),
        .alu_ctrl (alu_ctrl),
        .rf_we    (rf_we)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // same field positions for register and store/branch forms
    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(1 + ($unsigned($random(seed)) % 31));   // never x0
    endfunction

    task automatic drive(input logic [31:0] w, input logic st, input logic fl);
        @(posedge clk);
        #2;
        instr_in = w;
        stall    = st;
        chng2nop = fl;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(32'h0, 1'b0, 1'b0);
    endtask

    task automatic issue_alone(input logic [31:0] w);
        drive(w, 1'b0, 1'b0);
        idle(1);    // zero word clears the previous destination
    endtask

    task automatic finish_test(input string name);
        int failures;
        idle(5);    // let the last writeback group drain
        failures      = cu_top_inst.cu_props_inst.errors - errors_before;
        errors_before = cu_top_inst.cu_props_inst.errors;
        tests_run++;
        if (failures == 0) begin
            $display("%-12s done, no failures", name);
        end else begin
            tests_failed++;
            $display("Error %s: expected 0 assertion failures, actual %0d", name, failures);
        end
    endtask

    task automatic test_reset();
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        nrst = 1'b1;
        finish_test("reset");
    endtask

    task automatic test_stage_align();
        logic [6:0] ops [9] = '{OP_BRANCH, OP_JAL, OP_JALR, OP_LOAD, OP_STORE,
                                OP_ITYPE, OP_RTYPE, OP_FENCE, OP_CSTYPE};
        foreach (ops[i])
            issue_alone(encode(7'h0, pick_reg(), pick_reg(), 3'b000, pick_reg(), ops[i]));
        issue_alone(32'h0);
        finish_test("stage_align");
    endtask

    task automatic test_alu_code();
        logic [6:0] f7;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                f7 = (alt != 0) ? 7'b0100000 : 7'b0000000;
                issue_alone(encode(f7, pick_reg(), pick_reg(), 3'(f3), pick_reg(), OP_RTYPE));
                issue_alone(encode(f7, pick_reg(), pick_reg(), 3'(f3), pick_reg(), OP_ITYPE));
            end
        end
        issue_alone(encode(7'h12, 5'h3, 5'h7, 3'b101, pick_reg(), OP_LUI));
        issue_alone(encode(7'h0, 5'h0, pick_reg(), 3'b010, pick_reg(), OP_LOAD));
        issue_alone(encode(7'h0, pick_reg(), pick_reg(), 3'b010, 5'h4, OP_STORE));
        finish_test("alu_code");
    endtask

    task automatic test_flush();
        logic [4:0] r;
        r = pick_reg();
        drive(encode(7'h0, 5'h0, pick_reg(), 3'b010, r, OP_LOAD), 1'b0, 1'b1);
        drive(encode(7'h0, pick_reg(), r, 3'b000, pick_reg(), OP_RTYPE), 1'b0, 1'b0);
        finish_test("flush");
    endtask

    task automatic test_one_cycle_stalls();
        logic [4:0] r;
        logic [4:0] s;
        r = pick_reg();
        s = 5'((r % 31) + 1);
        // load then dependent add, add shown again after the hold
        drive(encode(7'h0, 5'h0, s, 3'b010, r, OP_LOAD), 1'b0, 1'b0);
        repeat (2) drive(encode(7'h0, s, r, 3'b000, s, OP_RTYPE), 1'b0, 1'b0);
        idle(1);
        drive(encode(7'h0, 5'h0, s, 3'b000, r, OP_ITYPE), 1'b0, 1'b0);
        repeat (2) drive(encode(7'h0, r, s, 3'b000, 5'h8, OP_BRANCH), 1'b0, 1'b0);
        idle(1);
        drive(encode(7'h0, s, r, 3'b000, s, OP_RTYPE), 1'b1, 1'b0);
        drive(encode(7'h0, s, r, 3'b000, s, OP_RTYPE), 1'b0, 1'b0);
        idle(1);
        // x0 never creates a dependency
        drive(encode(7'h0, 5'h0, r, 3'b010, 5'h0, OP_LOAD), 1'b0, 1'b0);
        drive(encode(7'h0, 5'h0, 5'h0, 3'b000, s, OP_RTYPE), 1'b0, 1'b0);
        finish_test("one_cycle");
    endtask

    task automatic test_mem_wait();
        logic [4:0] r;
        logic [4:0] s;
        r = pick_reg();
        s = 5'((r % 31) + 1);
        drive(encode(7'h0, 5'h0, s, 3'b010, r, OP_LOAD), 1'b0, 1'b0);
        repeat (MEM_DELAY + 2) drive(encode(7'h0, s, r, 3'b001, 5'h6, OP_BRANCH), 1'b0, 1'b0);
        finish_test("mem_wait");
    endtask

    initial begin
        nrst     = 1'b0;
        stall    = 1'b0;
        chng2nop = 1'b0;
        instr_in = 32'h0;
        test_reset();
        test_stage_align();
        test_alu_code();
        test_flush();
        test_one_cycle_stalls();
        test_mem_wait();
        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors_before);
        if (tests_failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* build.f */
logic/cu_pkg.sv
logic/cw_bundle_if.sv
logic/cw_decoder.sv
logic/hazard_unit.sv
logic/stall_fsm.sv
logic/delay_counter.sv
logic/cw_pipeline.sv
logic/cu_top.sv
bench/cu_props.sv
bench/tb_cu.sv
